// File: tb.f
+incdir+sim
common/exec_pkg.sv
common/exec_op_if.sv
hdl/operand_select.sv
alu/logic_unit.sv
alu/barrel_shifter.sv
hdl/result_merge.sv
hdl/exec_stage.sv
sim/tb_exec_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Testbench passed" $(LOG) || { echo "no pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/exec_checks.svh
`ifndef EXEC_CHECKS_SVH
`define EXEC_CHECKS_SVH

function automatic word_t rand_word();
    return word_t'($urandom());
endfunction

function automatic word_t edge_val(int i);
    case (i)
        0:       return 32'h0000_0000;
        1:       return 32'hffff_ffff;
        2:       return 32'h8000_0000;    // sign bit only
        default: return 32'h7fff_ffff;
    endcase
endfunction

// value after forwarding, unknown codes keep the register value
function automatic word_t forwarded(fwd_sel_t sel, word_t reg_val, word_t alu_val,
                                    word_t mem_val);
    if (sel == FWD_ALU)
        return alu_val;
    if (sel == FWD_MEM)
        return mem_val;
    return reg_val;
endfunction

function automatic word_t ref_result(alu_func_t func, word_t a, word_t b);
    shamt_t sh;
    sh = a[SHAMT_W-1:0];
    case (func)
        FUNC_PA:   return a;
        FUNC_PB:   return b;
        FUNC_ADD:  return a + b;
        FUNC_SUB:  return a - b;
        FUNC_SUBU: return a - b;
        FUNC_OR:   return a | b;
        FUNC_AND:  return a & b;
        FUNC_XOR:  return a ^ b;
        FUNC_NOR:  return ~(a | b);
        FUNC_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        FUNC_SLTU: return (a < b) ? 32'd1 : 32'd0;
        FUNC_SLL:  return b << sh;
        FUNC_SRL:  return b >> sh;
        FUNC_SRA:  return word_t'($signed(b) >>> sh);
        default:   return '0;
    endcase
endfunction

task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
    begin
        $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        errors++;
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
    begin
        $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        errors++;
    end
endtask

task automatic take_result();
    if (exp_res_q.size() == 0)
    begin
        $display("result came out with no operation pending");
        errors++;
    end
    else
    begin
        check_word("alu_res_o", alu_res, exp_res_q.pop_front());
        check_word("store_data_o", store_data, exp_store_q.pop_front());
        checked++;
    end
endtask

// called at a falling edge, returns at the falling edge after acceptance
task automatic issue_op(alu_func_t func, muxa_sel_t ma, muxb_sel_t mb, fwd_sel_t fa,
                        fwd_sel_t fb, fwd_sel_t fs, word_t pc_v, word_t rs_v, word_t rt_v,
                        word_t ext_v, word_t alu_v, word_t mem_v);
    word_t a;
    word_t b;
    a = forwarded(fa, rs_v, alu_v, mem_v);
    if (ma == MUXA_PC)
        a = pc_v + PC_STEP;
    else if (ma == MUXA_EXT)
        a = ext_v;
    b = (mb == MUXB_EXT) ? ext_v : forwarded(fb, rt_v, alu_v, mem_v);
    exp_res_q.push_back(ref_result(func, a, b));
    exp_store_q.push_back(forwarded(fs, rt_v, alu_v, mem_v));
    issued++;
    alu_func  = func;
    muxa_sel  = ma;
    muxb_sel  = mb;
    fwd_a     = fa;
    fwd_b     = fb;
    fwd_store = fs;
    pc        = pc_v;
    rs        = rs_v;
    rt        = rt_v;
    ext       = ext_v;
    fw_alu    = alu_v;
    fw_mem    = mem_v;
    op_valid  = 1'b1;
    @(posedge clk);
    while (!op_ready)
        @(posedge clk);
    @(negedge clk);
endtask

task automatic issue_alu(alu_func_t func, word_t a, word_t b);
    issue_op(func, MUXA_RS, MUXB_RT, FWD_NONE, FWD_NONE, FWD_NONE, rand_word(), a, b,
             rand_word(), rand_word(), rand_word());
endtask

task automatic wait_drain();
    op_valid = 1'b0;
    while (exp_res_q.size() != 0)
        @(negedge clk);
endtask

task automatic test_reset_latency();
    check_flag("op_ready_o", op_ready, 1'b1);
    check_flag("res_valid_o", res_valid, 1'b0);
    issue_alu(FUNC_ADD, rand_word(), rand_word());
    op_valid = 1'b0;
    check_flag("res_valid_o", res_valid, 1'b0);    // still in the operand register
    @(negedge clk);
    check_flag("res_valid_o", res_valid, 1'b1);
    wait_drain();
endtask

task automatic test_logic_unit();
    alu_func_t codes[11];
    alu_func_t unused[3];
    codes  = '{FUNC_PA, FUNC_PB, FUNC_ADD, FUNC_SUB, FUNC_SUBU, FUNC_OR, FUNC_AND,
               FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_SLTU};
    unused = '{FUNC_NOP, alu_func_t'(15), alu_func_t'(31)};
    foreach (codes[c])
    begin
        for (int i = 0; i < 16; i++)
            issue_alu(codes[c], edge_val(i / 4), edge_val(i % 4));
        for (int i = 0; i < 8; i++)
            issue_alu(codes[c], rand_word(), rand_word());
    end
    foreach (unused[c])
    begin
        for (int i = 0; i < 4; i++)
            issue_alu(unused[c], rand_word(), rand_word());
    end
    wait_drain();
endtask

task automatic test_shifter();
    alu_func_t kinds[3];
    word_t     a;
    word_t     b;
    kinds = '{FUNC_SLL, FUNC_SRL, FUNC_SRA};
    foreach (kinds[k])
    begin
        for (int s = 0; s < 32; s++)
        begin
            a = rand_word();
            a[SHAMT_W-1:0] = shamt_t'(s);    // upper bits of rs stay random
            b = rand_word();
            b[WORD_W-1] = s[0];
            issue_alu(kinds[k], a, b);
        end
    end
    wait_drain();
endtask

task automatic test_operand_sources();
    word_t pc_v;
    for (int i = 0; i < 4; i++)
    begin
        pc_v = (i == 0) ? 32'hffff_fffc : rand_word();    // wraps on the first pass
        issue_op(FUNC_PA, MUXA_PC, MUXB_RT, FWD_NONE, FWD_NONE, FWD_NONE, pc_v,
                 rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
        issue_op(FUNC_PA, MUXA_EXT, MUXB_RT, FWD_NONE, FWD_NONE, FWD_NONE, pc_v,
                 rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
        issue_op(FUNC_PB, MUXA_RS, MUXB_EXT, FWD_NONE, FWD_NONE, FWD_NONE, pc_v,
                 rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
        issue_op(FUNC_ADD, muxa_sel_t'(3), MUXB_EXT, FWD_NONE, FWD_NONE, FWD_NONE, pc_v,
                 rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
    end
    wait_drain();
endtask

task automatic test_forwarding();
    fwd_sel_t sel;
    for (int r = 0; r < 2; r++)
    begin
        for (int s = 0; s < 4; s++)
        begin
            sel = fwd_sel_t'(s);
            issue_op(FUNC_PA, MUXA_RS, MUXB_RT, sel, FWD_NONE, FWD_NONE, rand_word(),
                     rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
            issue_op(FUNC_PB, MUXA_RS, MUXB_RT, FWD_NONE, sel, FWD_NONE, rand_word(),
                     rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
            issue_op(FUNC_NOP, MUXA_RS, MUXB_RT, FWD_NONE, FWD_NONE, sel, rand_word(),
                     rand_word(), rand_word(), rand_word(), rand_word(), rand_word());
        end
    end
    wait_drain();
endtask

task automatic test_back_pressure();
    bp_run = 1'b1;
    for (int n = 0; n < BP_OPS; n++)
    begin
        issue_op(alu_func_t'($urandom_range(0, 15)), muxa_sel_t'($urandom_range(0, 3)),
                 muxb_sel_t'($urandom_range(0, 1)), fwd_sel_t'($urandom_range(0, 3)),
                 fwd_sel_t'($urandom_range(0, 3)), fwd_sel_t'($urandom_range(0, 3)),
                 rand_word(), rand_word(), rand_word(), rand_word(), rand_word(),
                 rand_word());
    end
    bp_run    = 1'b0;
    res_ready = 1'b1;
    wait_drain();
endtask

`endif

// File: sim/tb_exec_stage.sv
`timescale 1ns/10ps

module tb_exec_stage import exec_pkg::*; ();

    localparam int PC_STEP   = 4;
    localparam int LOGIC_OPS = 11 * 24 + 3 * 4;
    localparam int SHIFT_OPS = 3 * 32;
    localparam int SRC_OPS   = 16;
    localparam int FWD_OPS   = 24;
    localparam int BP_OPS    = 200;
    localparam int TOTAL_OPS = 1 + LOGIC_OPS + SHIFT_OPS + SRC_OPS + FWD_OPS + BP_OPS;

    logic      clk;
    logic      rst;
    logic      op_valid;
    logic      op_ready;
    alu_func_t alu_func;
    muxa_sel_t muxa_sel;
    muxb_sel_t muxb_sel;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    fwd_sel_t  fwd_store;
    word_t     pc;
    word_t     rs;
    word_t     rt;
    word_t     ext;
    word_t     fw_alu;
    word_t     fw_mem;
    logic      res_valid;
    logic      res_ready;
    word_t     alu_res;
    word_t     store_data;

    int    errors  = 0;
    int    issued  = 0;
    int    checked = 0;
    int    held    = 0;    // items inside the DUT
    logic  bp_run  = 1'b0;
    word_t exp_res_q[$];
    word_t exp_store_q[$];

    exec_stage #(
        .PC_STEP (PC_STEP)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid),
        .op_ready_o   (op_ready),
        .alu_func_i   (alu_func),
        .muxa_sel_i   (muxa_sel),
        .muxb_sel_i   (muxb_sel),
        .fwd_a_i      (fwd_a),
        .fwd_b_i      (fwd_b),
        .fwd_store_i  (fwd_store),
        .pc_i         (pc),
        .rs_i         (rs),
        .rt_i         (rt),
        .ext_i        (ext),
        .fw_alu_i     (fw_alu),
        .fw_mem_i     (fw_mem),
        .res_valid_o  (res_valid),
        .res_ready_i  (res_ready),
        .alu_res_o    (alu_res),
        .store_data_o (store_data)
    );

    `include "exec_checks.svh"

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        repeat (TOTAL_OPS * 20 + 200) @(posedge clk);
        $display("timeout: results still missing after %0d cycles", TOTAL_OPS * 20 + 200);
        $display("Testbench failed");
        $finish;
    end

    // random stall pattern on the result side
    always @(negedge clk)
    begin
        if (bp_run)
            res_ready = ($urandom_range(0, 1) == 1);
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            check_flag("op_ready_o", op_ready, (held < 2) || res_ready);
            if (res_valid && res_ready)
                take_result();
            if (op_valid && op_ready)
                held = held + 1;
            if (res_valid && res_ready)
                held = held - 1;
        end
    end

    initial
    begin
        void'($urandom(95));
        rst       = 1'b0;
        op_valid  = 1'b0;
        alu_func  = FUNC_NOP;
        muxa_sel  = MUXA_RS;
        muxb_sel  = MUXB_RT;
        fwd_a     = FWD_NONE;
        fwd_b     = FWD_NONE;
        fwd_store = FWD_NONE;
        pc        = '0;
        rs        = '0;
        rt        = '0;
        ext       = '0;
        fw_alu    = '0;
        fw_mem    = '0;
        res_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_reset_latency();
        test_logic_unit();
        test_shifter();
        test_operand_sources();
        test_forwarding();
        test_back_pressure();

        if (checked != issued)
        begin
            $display("result count mismatch: %0d issued, %0d checked", issued, checked);
            errors++;
        end
        $display("errors: %0d, issued: %0d, checked: %0d", errors, issued, checked);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/10ps

module exec_stage import exec_pkg::*; #(
    parameter int PC_STEP = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      op_valid_i,
    output logic      op_ready_o,
    input  alu_func_t alu_func_i,
    input  muxa_sel_t muxa_sel_i,
    input  muxb_sel_t muxb_sel_i,
    input  fwd_sel_t  fwd_a_i,
    input  fwd_sel_t  fwd_b_i,
    input  fwd_sel_t  fwd_store_i,
    input  word_t     pc_i,
    input  word_t     rs_i,
    input  word_t     rt_i,
    input  word_t     ext_i,
    input  word_t     fw_alu_i,
    input  word_t     fw_mem_i,
    output logic      res_valid_o,
    input  logic      res_ready_i,
    output word_t     alu_res_o,
    output word_t     store_data_o
);

    word_t logic_res;
    word_t shift_res;

    exec_op_if op_bus ();    // registered operands

    operand_select #(
        .PC_STEP (PC_STEP)
    ) u_operand_select (
        .clk         (clk),
        .rst         (rst),
        .op_valid_i  (op_valid_i),
        .op_ready_o  (op_ready_o),
        .alu_func_i  (alu_func_i),
        .muxa_sel_i  (muxa_sel_i),
        .muxb_sel_i  (muxb_sel_i),
        .fwd_a_i     (fwd_a_i),
        .fwd_b_i     (fwd_b_i),
        .fwd_store_i (fwd_store_i),
        .pc_i        (pc_i),
        .rs_i        (rs_i),
        .rt_i        (rt_i),
        .ext_i       (ext_i),
        .fw_alu_i    (fw_alu_i),
        .fw_mem_i    (fw_mem_i),
        .op          (op_bus.src)
    );

    logic_unit u_logic_unit (
        .op       (op_bus.unit),
        .result_o (logic_res)
    );

    barrel_shifter u_barrel_shifter (
        .op       (op_bus.unit),
        .result_o (shift_res)
    );

    result_merge u_result_merge (
        .clk          (clk),
        .rst          (rst),
        .op           (op_bus.sink),
        .logic_res_i  (logic_res),
        .shift_res_i  (shift_res),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .alu_res_o    (alu_res_o),
        .store_data_o (store_data_o)
    );

endmodule

// File: hdl/result_merge.sv
`timescale 1ns/10ps

module result_merge import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    exec_op_if.sink  op,
    input  word_t    logic_res_i,
    input  word_t    shift_res_i,
    output logic     res_valid_o,
    input  logic     res_ready_i,
    output word_t    alu_res_o,
    output word_t    store_data_o
);

    word_t merged;
    logic  load;

    // each unit gives zero outside its own codes
    assign merged = logic_res_i | shift_res_i;

    assign op.ready = !res_valid_o || res_ready_i;
    assign load     = op.valid && op.ready;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            res_valid_o <= 1'b0;
        end
        else if (op.ready)
        begin
            res_valid_o <= op.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            alu_res_o    <= merged;
            store_data_o <= op.store_data;
        end
    end

endmodule

// File: alu/barrel_shifter.sv
`timescale 1ns/10ps

module barrel_shifter import exec_pkg::*; (
    exec_op_if.unit op,
    output word_t   result_o
);

    // left shift runs through the right shifter on bit-reversed data
    function automatic word_t bit_rev(word_t w);
        word_t r;
        for (int i = 0; i < WORD_W; i++)
        begin
            r[WORD_W-1-i] = w[i];
        end
        return r;
    endfunction

    shamt_t amt;
    logic   is_shift;
    logic   is_left;
    logic   fill;
    word_t  data;

    assign amt      = op.op_a[SHAMT_W-1:0];
    assign is_left  = (op.func == FUNC_SLL);
    assign is_shift = is_left || (op.func == FUNC_SRL) || (op.func == FUNC_SRA);
    assign fill     = (op.func == FUNC_SRA) ? op.op_b[WORD_W-1] : 1'b0;

    always_comb
    begin
        data = is_left ? bit_rev(op.op_b) : op.op_b;
        for (int i = 0; i < SHAMT_W; i++)
        begin
            if (amt[i])    // stage i moves by 2**i
            begin
                data = (data >> (2 ** i)) | ({WORD_W{fill}} & ~({WORD_W{1'b1}} >> (2 ** i)));
            end
        end
    end

    assign result_o = !is_shift ? '0 : (is_left ? bit_rev(data) : data);

endmodule

// File: alu/logic_unit.sv
`timescale 1ns/10ps

module logic_unit import exec_pkg::*; (
    exec_op_if.unit op,
    output word_t   result_o
);

    word_t a;
    word_t b;

    assign a = op.op_a;
    assign b = op.op_b;

    always_comb
    begin
        case (op.func)
            FUNC_PA:   result_o = a;
            FUNC_PB:   result_o = b;
            FUNC_ADD:  result_o = a + b;
            FUNC_SUB,
            FUNC_SUBU: result_o = a - b;    // no overflow trap here
            FUNC_OR:   result_o = a | b;
            FUNC_AND:  result_o = a & b;
            FUNC_XOR:  result_o = a ^ b;
            FUNC_NOR:  result_o = ~(a | b);
            FUNC_SLT:
            begin
                result_o = word_t'($signed(a) < $signed(b));
            end
            FUNC_SLTU:
            begin
                result_o = word_t'(a < b);
            end
            default:   result_o = '0;       // shifts, nop, unused codes
        endcase
    end

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/10ps

module operand_select import exec_pkg::*; #(
    parameter int PC_STEP = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      op_valid_i,
    output logic      op_ready_o,
    input  alu_func_t alu_func_i,
    input  muxa_sel_t muxa_sel_i,
    input  muxb_sel_t muxb_sel_i,
    input  fwd_sel_t  fwd_a_i,
    input  fwd_sel_t  fwd_b_i,
    input  fwd_sel_t  fwd_store_i,
    input  word_t     pc_i,
    input  word_t     rs_i,
    input  word_t     rt_i,
    input  word_t     ext_i,
    input  word_t     fw_alu_i,
    input  word_t     fw_mem_i,
    exec_op_if.src    op
);

    word_t rs_fwd;
    word_t rt_fwd;
    word_t store_fwd;
    word_t link_addr;
    word_t op_a_nxt;
    word_t op_b_nxt;
    logic  accept;

    function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, word_t alu_val,
                                       word_t mem_val);
        case (sel)
            FWD_ALU: return alu_val;
            FWD_MEM: return mem_val;
            default: return reg_val;    // FWD_NONE and unused codes
        endcase
    endfunction

    assign rs_fwd    = fwd_pick(fwd_a_i, rs_i, fw_alu_i, fw_mem_i);
    assign rt_fwd    = fwd_pick(fwd_b_i, rt_i, fw_alu_i, fw_mem_i);
    assign store_fwd = fwd_pick(fwd_store_i, rt_i, fw_alu_i, fw_mem_i);
    assign link_addr = pc_i + word_t'(PC_STEP);

    always_comb
    begin
        case (muxa_sel_i)
            MUXA_PC:  op_a_nxt = link_addr;
            MUXA_EXT: op_a_nxt = ext_i;
            default:  op_a_nxt = rs_fwd;
        endcase
    end

    assign op_b_nxt = (muxb_sel_i == MUXB_EXT) ? ext_i : rt_fwd;

    // stage is free when empty or when it drains this cycle
    assign op_ready_o = !op.valid || op.ready;
    assign accept     = op_valid_i && op_ready_o;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            op.valid <= 1'b0;
        end
        else if (op_ready_o)
        begin
            op.valid <= op_valid_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op.op_a       <= op_a_nxt;
            op.op_b       <= op_b_nxt;
            op.func       <= alu_func_i;
            op.store_data <= store_fwd;
        end
    end

endmodule

// File: common/exec_op_if.sv
`timescale 1ns/10ps

interface exec_op_if import exec_pkg::*; ();

    word_t     op_a;
    word_t     op_b;
    alu_func_t func;
    word_t     store_data;
    logic      valid;
    logic      ready;

    modport src (
        output op_a, op_b, func, store_data, valid,
        input  ready
    );

    modport unit (
        input op_a, op_b, func
    );

    modport sink (
        input  valid, func, store_data,
        output ready
    );

endinterface

// File: common/exec_pkg.sv
package exec_pkg;

    localparam int WORD_W  = 32;
    localparam int SHAMT_W = 5;
    localparam int FUNC_W  = 5;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [SHAMT_W-1:0] shamt_t;
    typedef logic [FUNC_W-1:0]  alu_func_t;
    typedef logic [1:0]         muxa_sel_t;
    typedef logic               muxb_sel_t;
    typedef logic [1:0]         fwd_sel_t;

    // execute function codes
    localparam alu_func_t FUNC_NOP  = 5'd0;
    localparam alu_func_t FUNC_PA   = 5'd1;    // pass operand a
    localparam alu_func_t FUNC_PB   = 5'd2;    // pass operand b
    localparam alu_func_t FUNC_ADD  = 5'd3;
    localparam alu_func_t FUNC_SUB  = 5'd4;
    localparam alu_func_t FUNC_SUBU = 5'd5;
    localparam alu_func_t FUNC_OR   = 5'd6;
    localparam alu_func_t FUNC_AND  = 5'd7;
    localparam alu_func_t FUNC_XOR  = 5'd8;
    localparam alu_func_t FUNC_NOR  = 5'd9;
    localparam alu_func_t FUNC_SLT  = 5'd10;   // signed compare
    localparam alu_func_t FUNC_SLTU = 5'd11;   // unsigned compare
    localparam alu_func_t FUNC_SLL  = 5'd12;
    localparam alu_func_t FUNC_SRL  = 5'd13;
    localparam alu_func_t FUNC_SRA  = 5'd14;

    // operand a source
    localparam muxa_sel_t MUXA_RS  = 2'd0;
    localparam muxa_sel_t MUXA_PC  = 2'd1;     // link address
    localparam muxa_sel_t MUXA_EXT = 2'd2;

    // operand b source
    localparam muxb_sel_t MUXB_RT  = 1'b0;
    localparam muxb_sel_t MUXB_EXT = 1'b1;

    // forwarding choice
    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_ALU  = 2'd1;
    localparam fwd_sel_t FWD_MEM  = 2'd2;

endpackage
